// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_rv_decode -f files.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/tb_rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module tb_rv_decode
  import rv_decode_pkg::*;
();

  localparam int NUM_TESTS   = 5;
  localparam int ACK_TIMEOUT = 50;

  logic        clk;
  logic        rst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [4:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  integer seed;
  int     errors;
  int     failures;
  int     next_tag;
  int     req_tag; // tags the request now driven on the bus
  int     ack_tag;

  rv_decode_top i_dut (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // an ack answers whatever request was on the bus at the edge before it
  always @(posedge clk) begin
    ack_tag <= req_tag;
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", NUM_TESTS * 2000);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic insn_fmt_e decode_fmt(input logic [31:0] w);
    case (w[6:0])
      7'b0110011:                                                  return FMT_R;
      7'b0010011, 7'b0000011, 7'b1100111, 7'b0001111, 7'b1110011: return FMT_I;
      7'b0100011:                                                  return FMT_S;
      7'b1100011:                                                  return FMT_SB;
      7'b0110111, 7'b0010111:                                      return FMT_U;
      7'b1101111:                                                  return FMT_UJ;
      default:                                                     return FMT_BAD;
    endcase
  endfunction

  function automatic logic [15:0] decode_flag(input logic [31:0] w);
    logic [15:0] f;
    logic [6:0]  op;
    logic [2:0]  f3;
    insn_fmt_e   fm;
    op = w[6:0];
    f3 = w[14:12];
    fm = decode_fmt(w);
    f  = 16'h0000;
    case (fm)
      FMT_R:         f[3:0] = 4'b0111;
      FMT_I:         f[3:0] = 4'b1011;
      FMT_S, FMT_SB: f[3:0] = 4'b1110;
      FMT_U, FMT_UJ: f[3:0] = 4'b1001;
      default:       f[3:0] = 4'b0000;
    endcase
    if (fm != FMT_BAD) begin
      f[`IS_SIGNED_BIT] = !((op == 7'b1110011) && f3[2]); // csr immediates are unsigned
    end
    f[`IS_SHIFT_BIT]   = (op == 7'b0010011) && (f3[1:0] == 2'b01);
    f[`IS_LOAD_BIT]    = (op == 7'b0000011);
    f[`IS_BRACKET_BIT] = (op == 7'b0000011) || (op == 7'b0100011) || (op == 7'b1100111);
    if ((op == 7'b0001111) || ((op == 7'b1110011) && (f3 == 3'b000))) begin
      f[`IS_DIFF_BIT] = 1'b1;
      f[3:0]          = 4'b0000; // fence, ecall and ebreak name no operands
    end
    return f;
  endfunction

  function automatic logic [31:0] decode_imm(input logic [31:0] w);
    logic [31:0] v;
    logic [15:0] f;
    int          width;
    f     = decode_flag(w);
    v     = 32'd0;
    width = 0;
    case (decode_fmt(w))
      FMT_I: begin
        v     = {20'd0, w[31:20]};
        width = 12;
      end
      FMT_S: begin
        v     = {20'd0, w[31:25], w[11:7]};
        width = 12;
      end
      FMT_SB: begin
        v     = {19'd0, w[31], w[7], w[30:25], w[11:8], 1'b0};
        width = 13;
      end
      FMT_UJ: begin
        v     = {11'd0, w[31], w[19:12], w[20], w[30:21], 1'b0};
        width = 21;
      end
      FMT_U:   v = {w[31:12], 12'd0};
      default: v = 32'd0;
    endcase
    if ((width > 0) && f[`IS_SIGNED_BIT] && v[width-1]) begin
      v = v | (32'hffff_ffff << width);
    end
    if (f[`IS_SHIFT_BIT]) begin
      v[10] = 1'b0;
    end
    return v;
  endfunction

  function automatic logic [31:0] abi_name_of(input logic [4:0] n);
    logic [7:0] c0;
    logic [7:0] c1;
    logic [7:0] c2;
    int         num;
    int         k;
    num = int'(n);
    c2  = " ";
    if (num == 0) begin
      return "zero";
    end
    if (num <= 4) begin
      c0 = (num == 1) ? "r" : (num == 2) ? "s" : (num == 3) ? "g" : "t";
      c1 = (num == 1) ? "a" : "p";
    end else begin
      // groups run t0-t2, s0-s1, a0-a7, s2-s11, t3-t6
      c0 = ((num <= 7) || (num >= 28)) ? "t" : ((num <= 9) || (num >= 18)) ? "s" : "a";
      k  = (num <= 7) ? num - 5 : (num <= 9) ? num - 8 : (num <= 17) ? num - 10 :
           (num <= 27) ? num - 16 : num - 25;
      if (k >= 10) begin
        c1 = "1";
        c2 = 8'(48 + k - 10);
      end else begin
        c1 = 8'(48 + k);
      end
    end
    return {c0, c1, c2, " "};
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // puts back whatever request it displaced, so a held write survives other cycles
  task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata);
    logic        saved_cyc;
    logic        saved_stb;
    logic        saved_we;
    logic [4:0]  saved_adr;
    logic [31:0] saved_dat;
    int          saved_tag;
    int          my_tag;
    int          waited;
    bit          got_ack;
    @(posedge clk);
    saved_cyc = wb_cyc;
    saved_stb = wb_stb;
    saved_we  = wb_we;
    saved_adr = wb_adr;
    saved_dat = wb_dat_w;
    saved_tag = req_tag;
    next_tag++;
    my_tag    = next_tag;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wb_sel   <= 4'hf;
    req_tag  <= my_tag;
    waited  = 0;
    got_ack = 1'b0;
    rdata   = 32'd0;
    while (!got_ack && (waited < ACK_TIMEOUT)) begin
      @(negedge clk);
      if (wb_ack && (ack_tag == my_tag)) begin
        got_ack = 1'b1;
        rdata   = wb_dat_r;
      end
      waited++;
    end
    if (!got_ack) begin
      failures++;
      $display("%0t ns: the DUT gave no ack within %0d cycles for address %h", $time,
               ACK_TIMEOUT, adr);
    end
    @(posedge clk);
    wb_cyc   <= saved_cyc;
    wb_stb   <= saved_stb;
    wb_we    <= saved_we;
    wb_adr   <= saved_adr;
    wb_dat_w <= saved_dat;
    req_tag  <= saved_tag;
  endtask

  task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
    logic [31:0] ignored;
    bus_cycle(1'b1, adr, dat, ignored);
  endtask

  task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 32'd0, dat);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
  endtask

  task automatic wait_for_entry();
    logic [31:0] status;
    int          polls;
    status = 32'd0;
    polls  = 0;
    while ((status == 32'd0) && (polls < ACK_TIMEOUT)) begin
      wb_read(`REG_STATUS, status);
      polls++;
    end
    if (status == 32'd0) begin
      failures++;
      $display("%0t ns: the result queue stayed empty after an instruction write", $time);
    end
  endtask

  task automatic check_entry(input logic [31:0] w);
    logic [31:0] rdata;
    logic [31:0] exp_fields;
    exp_fields = {decode_flag(w), 1'b0, w[11:7], w[19:15], w[24:20]};
    wait_for_entry();
    wb_read(`REG_FIELDS, rdata);
    expect_equal("REG_FIELDS", rdata, exp_fields);
    wb_read(`REG_IMM, rdata);
    expect_equal("REG_IMM", rdata, decode_imm(w));
    wb_read(`REG_RD_NAME, rdata);
    expect_equal("REG_RD_NAME", rdata, abi_name_of(w[11:7]));
    wb_read(`REG_RS1_NAME, rdata);
    expect_equal("REG_RS1_NAME", rdata, abi_name_of(w[19:15]));
    wb_read(`REG_RS2_NAME, rdata);
    expect_equal("REG_RS2_NAME", rdata, abi_name_of(w[24:20]));
  endtask

  task automatic pop_entry();
    wb_write(`REG_POP, 32'd0);
  endtask

  task automatic format_coverage();
    logic [31:0] insns [6];
    insns[0] = {7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011};   // add gp, ra, sp
    insns[1] = {12'hfec, 5'd11, 3'b000, 5'd10, 7'b0010011};           // addi a0, a1, -20
    insns[2] = {7'd0, 5'd8, 5'd2, 3'b010, 5'd12, 7'b0100011};
    insns[3] = {1'b1, 6'b111111, 5'd6, 5'd5, 3'b000, 4'b1000, 1'b1, 7'b1100011}; // beq -16
    insns[4] = {20'habcde, 5'd7, 7'b0110111};
    insns[5] = {1'b1, 10'h3f0, 1'b1, 8'hff, 5'd1, 7'b1101111};        // jal with a back offset
    foreach (insns[i]) begin
      wb_write(`REG_INSN, insns[i]);
      check_entry(insns[i]);
      pop_entry();
    end
  endtask

  task automatic flag_rules();
    logic [31:0] insns [4];
    insns[0] = {7'b0100000, 5'd7, 5'd6, 3'b101, 5'd5, 7'b0010011}; // srai t0, t1, 7
    insns[1] = {12'hff8, 5'd2, 3'b010, 5'd10, 7'b0000011};        // lw a0, -8(sp)
    insns[2] = {12'hc00, 5'd5, 3'b101, 5'd1, 7'b1110011};         // csrrwi on a csr with bit 11 set
    insns[3] = 32'h0000_0073;
    foreach (insns[i]) begin
      wb_write(`REG_INSN, insns[i]);
      check_entry(insns[i]);
      pop_entry();
    end
  endtask

  task automatic abi_names();
    logic [31:0] w;
    logic [4:0]  num [3];
    for (int k = 0; k < 11; k++) begin
      for (int j = 0; j < 3; j++) begin
        num[j] = 5'((3 * k + j) % 32);
      end
      w = {7'b0000000, num[2], num[1], 3'b000, num[0], 7'b0110011};
      wb_write(`REG_INSN, w);
      check_entry(w);
      pop_entry();
    end
  endtask

  task automatic queue_order();
    logic [31:0] sent [`RESULT_DEPTH+1];
    bit          pop_done;
    for (int i = 0; i < `RESULT_DEPTH; i++) begin
      sent[i] = $random(seed);
    end
    sent[`RESULT_DEPTH] = {12'd4, 5'd5, 3'b000, 5'd1, 7'b1100111}; // jalr ra, 4(t0)
    for (int i = 0; i < `RESULT_DEPTH; i++) begin
      wb_write(`REG_INSN, sent[i]);
    end
    pop_done = 1'b0;
    fork
      begin
        wb_write(`REG_INSN, sent[`RESULT_DEPTH]); // no free slot, so this waits for the pop
        if (!pop_done) begin
          failures++;
          $display("%0t ns: an instruction write was acked with the queue full", $time);
        end
      end
      begin
        repeat (10) @(negedge clk);
        check_entry(sent[0]);
        pop_entry();
        pop_done = 1'b1;
      end
    join
    for (int i = 1; i <= `RESULT_DEPTH; i++) begin
      check_entry(sent[i]);
      pop_entry();
    end
  endtask

  task automatic reset_idle();
    logic [31:0] rdata;
    logic [31:0] bad [2];
    bad[0] = 32'h1234_567f;
    bad[1] = 32'hfedc_ba0b;
    wb_write(`REG_INSN, {12'd4, 5'd2, 3'b000, 5'd1, 7'b0010011}); // addi ra, sp, 4
    wait_for_entry(); // the queue holds an entry when reset hits
    apply_reset();
    wb_read(`REG_STATUS, rdata);
    expect_equal("REG_STATUS", rdata, 32'd0);
    for (int a = `REG_FIELDS; a <= `REG_RS2_NAME; a += 4) begin
      wb_read(5'(a), rdata);
      expect_equal($sformatf("wb_dat_r at 0x%02h", a), rdata, 32'd0);
    end
    pop_entry();
    wb_read(`REG_STATUS, rdata);
    expect_equal("REG_STATUS", rdata, 32'd0);
    foreach (bad[i]) begin
      wb_write(`REG_INSN, bad[i]);
      check_entry(bad[i]);
      pop_entry();
    end
  endtask

  initial begin
    seed     = 32'h82e7;
    errors   = 0;
    failures = 0;
    next_tag = 0;
    req_tag  = 0;
    rst_n    = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 5'd0;
    wb_dat_w = 32'd0;
    wb_sel   = 4'h0;
    apply_reset();
    format_coverage();
    flag_rules();
    abi_names();
    queue_order();
    reset_idle();
    $display("tests done with %0d mismatches and %0d other errors", errors, failures);
    if ((errors == 0) && (failures == 0)) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/wb_decode_port.sv
rtl/insn_classifier.sv
rtl/operand_extract.sv
rtl/reg_abi_name.sv
rtl/decode_result_queue.sv
rtl/rv_decode_top.sv
dv/tb_rv_decode.sv

// File: rtl/decode_result_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module decode_result_queue
  import rv_decode_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      push,
  input  logic                      pop,
  input  logic [`REG_NUM_WIDTH-1:0] in_rd,
  input  logic [`REG_NUM_WIDTH-1:0] in_rs1,
  input  logic [`REG_NUM_WIDTH-1:0] in_rs2,
  input  logic [`INSN_WIDTH-1:0]    in_imm,
  input  logic [`FLAG_WIDTH-1:0]    in_flag,
  input  abi_name_t                 in_rd_name,
  input  abi_name_t                 in_rs1_name,
  input  abi_name_t                 in_rs2_name,
  output logic [`COUNT_WIDTH-1:0]   count,
  output logic [`REG_NUM_WIDTH-1:0] head_rd,
  output logic [`REG_NUM_WIDTH-1:0] head_rs1,
  output logic [`REG_NUM_WIDTH-1:0] head_rs2,
  output logic [`INSN_WIDTH-1:0]    head_imm,
  output logic [`FLAG_WIDTH-1:0]    head_flag,
  output abi_name_t                 head_rd_name,
  output abi_name_t                 head_rs1_name,
  output abi_name_t                 head_rs2_name
);

  localparam int PTR_W = $clog2(`RESULT_DEPTH);

  // the bus credits keep pushes from ever meeting a full queue
  logic [`REG_NUM_WIDTH-1:0] rd_mem   [`RESULT_DEPTH];
  logic [`REG_NUM_WIDTH-1:0] rs1_mem  [`RESULT_DEPTH];
  logic [`REG_NUM_WIDTH-1:0] rs2_mem  [`RESULT_DEPTH];
  logic [`INSN_WIDTH-1:0]    imm_mem  [`RESULT_DEPTH];
  logic [`FLAG_WIDTH-1:0]    flag_mem [`RESULT_DEPTH];
  abi_name_t                 name_mem [`RESULT_DEPTH][3];
  logic [PTR_W-1:0]          wr_ptr;
  logic [PTR_W-1:0]          rd_ptr;
  logic                      do_pop;

  assign do_pop = pop && (count != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps on its own, depth is a power of two
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      rd_mem[wr_ptr]      <= in_rd;
      rs1_mem[wr_ptr]     <= in_rs1;
      rs2_mem[wr_ptr]     <= in_rs2;
      imm_mem[wr_ptr]     <= in_imm;
      flag_mem[wr_ptr]    <= in_flag;
      name_mem[wr_ptr][0] <= in_rd_name;
      name_mem[wr_ptr][1] <= in_rs1_name;
      name_mem[wr_ptr][2] <= in_rs2_name;
    end
  end

  assign head_rd       = rd_mem[rd_ptr];
  assign head_rs1      = rs1_mem[rd_ptr];
  assign head_rs2      = rs2_mem[rd_ptr];
  assign head_imm      = imm_mem[rd_ptr];
  assign head_flag     = flag_mem[rd_ptr];
  assign head_rd_name  = name_mem[rd_ptr][0];
  assign head_rs1_name = name_mem[rd_ptr][1];
  assign head_rs2_name = name_mem[rd_ptr][2];

endmodule

`default_nettype wire

// File: rtl/insn_classifier.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module insn_classifier
  import rv_decode_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  logic [`INSN_WIDTH-1:0] insn,
  output logic                   out_valid,
  output logic [`INSN_WIDTH-1:0] out_insn,
  output insn_fmt_e              fmt,
  output logic [`FLAG_WIDTH-1:0] flag
);

  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_FENCE  = 7'b0001111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  logic [6:0]             opcode;
  logic [2:0]             funct3;
  insn_fmt_e              fmt_c;
  logic [`FLAG_WIDTH-1:0] flag_c;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];

  always_comb begin
    fmt_c  = FMT_BAD;
    flag_c = '0;
    case (opcode)
      OP_REG: fmt_c = FMT_R;
      OP_IMM: begin
        fmt_c = FMT_I;
        flag_c[`IS_SHIFT_BIT] = (funct3 == 3'b001) || (funct3 == 3'b101); // slli, srli, srai
      end
      OP_LOAD: begin
        fmt_c = FMT_I;
        flag_c[`IS_LOAD_BIT]    = 1'b1;
        flag_c[`IS_BRACKET_BIT] = 1'b1;
      end
      OP_JALR: begin
        fmt_c = FMT_I;
        flag_c[`IS_BRACKET_BIT] = 1'b1;
      end
      OP_STORE: begin
        fmt_c = FMT_S;
        flag_c[`IS_BRACKET_BIT] = 1'b1;
      end
      OP_BRANCH:        fmt_c = FMT_SB;
      OP_LUI, OP_AUIPC: fmt_c = FMT_U;
      OP_JAL:           fmt_c = FMT_UJ;
      OP_FENCE: begin
        fmt_c = FMT_I;
        flag_c[`IS_DIFF_BIT] = 1'b1;
      end
      OP_SYSTEM: begin
        fmt_c = FMT_I;
        flag_c[`IS_DIFF_BIT] = (funct3 == 3'b000); // ecall and ebreak take no operands
      end
      default: fmt_c = FMT_BAD;
    endcase

    if (fmt_c != FMT_BAD) begin
      // csr immediate forms carry a zero-extended uimm
      flag_c[`IS_SIGNED_BIT] = !((opcode == OP_SYSTEM) && funct3[2]);
      if (!flag_c[`IS_DIFF_BIT]) begin
        flag_c[`USE_IMM_BIT:`USE_RD_BIT] = default_mask(fmt_c);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_insn <= insn;
      fmt      <= fmt_c;
      flag     <= flag_c;
    end
  end

endmodule

`default_nettype wire

// File: rtl/operand_extract.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module operand_extract
  import rv_decode_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  input  logic [`INSN_WIDTH-1:0]    insn,
  input  insn_fmt_e                 fmt,
  input  logic [`FLAG_WIDTH-1:0]    in_flag,
  output logic                      out_valid,
  output logic [`REG_NUM_WIDTH-1:0] rd,
  output logic [`REG_NUM_WIDTH-1:0] rs1,
  output logic [`REG_NUM_WIDTH-1:0] rs2,
  output logic [`INSN_WIDTH-1:0]    imm,
  output logic [`FLAG_WIDTH-1:0]    flag
);

  logic                   sx;
  logic [3:0]             base_mask;
  logic [3:0]             mask_c;
  logic [`INSN_WIDTH-1:0] imm_c;
  logic [`FLAG_WIDTH-1:0] flag_c;

  assign sx = insn[31] && in_flag[`IS_SIGNED_BIT]; // sign fill, only for signed immediates

  always_comb begin
    imm_c = '0;
    case (fmt)
      FMT_I: begin
        imm_c = {{20{sx}}, insn[31:20]};
        if (in_flag[`IS_SHIFT_BIT]) begin
          imm_c[10] = 1'b0; // drops the srai selector, shamt stays
        end
      end
      FMT_S:  imm_c = {{20{sx}}, insn[31:25], insn[11:7]};
      FMT_SB: imm_c = {{19{sx}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      FMT_U:  imm_c = {insn[31:12], 12'd0};
      FMT_UJ: imm_c = {{11{sx}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      default: imm_c = '0; // FMT_R has no immediate, FMT_BAD gives nothing
    endcase
  end

  assign base_mask = default_mask(fmt);

  // fence, ecall and ebreak narrow the mask through the classifier flags
  always_comb begin
    if (in_flag[`IS_DIFF_BIT]) begin
      mask_c = base_mask & in_flag[`USE_IMM_BIT:`USE_RD_BIT];
    end else begin
      mask_c = base_mask;
    end
  end

  assign flag_c = {in_flag[`FLAG_WIDTH-1:`USE_IMM_BIT+1], mask_c};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      rd   <= insn[11:7];
      rs1  <= insn[19:15];
      rs2  <= insn[24:20];
      imm  <= imm_c;
      flag <= flag_c;
    end
  end

endmodule

`default_nettype wire

// File: rtl/reg_abi_name.sv
`timescale 1ns/1ps
`default_nettype none

module reg_abi_name
  import rv_decode_pkg::*;
(
  input  logic [4:0] reg_number,
  output abi_name_t  reg_name
);

  // short names carry trailing spaces so every entry is four characters
  always_comb begin
    case (reg_number)
      5'd0:  reg_name = "zero";
      5'd1:  reg_name = "ra  ";
      5'd2:  reg_name = "sp  ";
      5'd3:  reg_name = "gp  ";
      5'd4:  reg_name = "tp  ";
      5'd5:  reg_name = "t0  ";
      5'd6:  reg_name = "t1  ";
      5'd7:  reg_name = "t2  ";
      5'd8:  reg_name = "s0  "; // also the frame pointer
      5'd9:  reg_name = "s1  ";
      5'd10: reg_name = "a0  ";
      5'd11: reg_name = "a1  ";
      5'd12: reg_name = "a2  ";
      5'd13: reg_name = "a3  ";
      5'd14: reg_name = "a4  ";
      5'd15: reg_name = "a5  ";
      5'd16: reg_name = "a6  ";
      5'd17: reg_name = "a7  ";
      5'd18: reg_name = "s2  ";
      5'd19: reg_name = "s3  ";
      5'd20: reg_name = "s4  ";
      5'd21: reg_name = "s5  ";
      5'd22: reg_name = "s6  ";
      5'd23: reg_name = "s7  ";
      5'd24: reg_name = "s8  ";
      5'd25: reg_name = "s9  ";
      5'd26: reg_name = "s10 ";
      5'd27: reg_name = "s11 ";
      5'd28: reg_name = "t3  ";
      5'd29: reg_name = "t4  ";
      5'd30: reg_name = "t5  ";
      default: reg_name = "t6  ";
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/rv_decode_consts.svh
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

`define INSN_WIDTH    32
`define FLAG_WIDTH    16
`define REG_NUM_WIDTH 5

// operand mask in flag bits 3:0
`define USE_RD_BIT     0
`define USE_RS1_BIT    1
`define USE_RS2_BIT    2
`define USE_IMM_BIT    3
`define IS_SIGNED_BIT  4
`define IS_SHIFT_BIT   5
`define IS_LOAD_BIT    6
`define IS_BRACKET_BIT 7
`define IS_DIFF_BIT    8

`define RESULT_DEPTH 4 // power of two, 2 up to 16
`define COUNT_WIDTH  5 // holds 0 to RESULT_DEPTH

`define REG_INSN     5'h00
`define REG_STATUS   5'h04
`define REG_FIELDS   5'h08
`define REG_IMM      5'h0C
`define REG_RD_NAME  5'h10
`define REG_RS1_NAME 5'h14
`define REG_RS2_NAME 5'h18
`define REG_POP      5'h1C

`endif

// File: rtl/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_consts.svh"

package rv_decode_pkg;

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_SB,
    FMT_U,
    FMT_UJ,
    FMT_BAD
  } insn_fmt_e;

  typedef logic [31:0] abi_name_t; // four ASCII characters, first one in bits 31:24

  // operands a format uses when nothing narrows the mask
  function automatic logic [3:0] default_mask(insn_fmt_e fmt);
    logic [3:0] m;
    m = '0;
    case (fmt)
      FMT_R: begin
        m[`USE_RD_BIT]  = 1'b1;
        m[`USE_RS1_BIT] = 1'b1;
        m[`USE_RS2_BIT] = 1'b1;
      end
      FMT_I: begin
        m[`USE_RD_BIT]  = 1'b1;
        m[`USE_RS1_BIT] = 1'b1;
        m[`USE_IMM_BIT] = 1'b1;
      end
      FMT_S, FMT_SB: begin
        m[`USE_RS1_BIT] = 1'b1;
        m[`USE_RS2_BIT] = 1'b1;
        m[`USE_IMM_BIT] = 1'b1;
      end
      FMT_U, FMT_UJ: begin
        m[`USE_RD_BIT]  = 1'b1;
        m[`USE_IMM_BIT] = 1'b1;
      end
      default: m = '0;
    endcase
    return m;
  endfunction

endpackage

`default_nettype wire

// File: rtl/rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module rv_decode_top
  import rv_decode_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [4:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic [3:0]  wb_sel,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack
);

  logic                      insn_valid;
  logic [`INSN_WIDTH-1:0]    insn;
  logic                      pop;
  logic                      cls_valid;
  logic [`INSN_WIDTH-1:0]    cls_insn;
  insn_fmt_e                 cls_fmt;
  logic [`FLAG_WIDTH-1:0]    cls_flag;
  logic                      ex_valid;
  logic [`REG_NUM_WIDTH-1:0] ex_rd;
  logic [`REG_NUM_WIDTH-1:0] ex_rs1;
  logic [`REG_NUM_WIDTH-1:0] ex_rs2;
  logic [`INSN_WIDTH-1:0]    ex_imm;
  logic [`FLAG_WIDTH-1:0]    ex_flag;
  abi_name_t                 rd_name;
  abi_name_t                 rs1_name;
  abi_name_t                 rs2_name;
  logic [`COUNT_WIDTH-1:0]   count;
  logic [`REG_NUM_WIDTH-1:0] head_rd;
  logic [`REG_NUM_WIDTH-1:0] head_rs1;
  logic [`REG_NUM_WIDTH-1:0] head_rs2;
  logic [`INSN_WIDTH-1:0]    head_imm;
  logic [`FLAG_WIDTH-1:0]    head_flag;
  abi_name_t                 head_rd_name;
  abi_name_t                 head_rs1_name;
  abi_name_t                 head_rs2_name;

  wb_decode_port i_port (
    .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel,
    .wb_dat_r, .wb_ack, .insn_valid, .insn, .pop, .count,
    .head_flag, .head_imm, .head_rd, .head_rs1, .head_rs2,
    .head_rd_name, .head_rs1_name, .head_rs2_name
  );

  insn_classifier i_classifier (
    .clk, .rst_n,
    .in_valid (insn_valid),
    .insn     (insn),
    .out_valid(cls_valid),
    .out_insn (cls_insn),
    .fmt      (cls_fmt),
    .flag     (cls_flag)
  );

  operand_extract i_extract (
    .clk, .rst_n,
    .in_valid (cls_valid),
    .insn     (cls_insn),
    .fmt      (cls_fmt),
    .in_flag  (cls_flag),
    .out_valid(ex_valid),
    .rd       (ex_rd),
    .rs1      (ex_rs1),
    .rs2      (ex_rs2),
    .imm      (ex_imm),
    .flag     (ex_flag)
  );

  // names are looked up on the way into the queue
  reg_abi_name i_rd_name  (.reg_number(ex_rd),  .reg_name(rd_name));
  reg_abi_name i_rs1_name (.reg_number(ex_rs1), .reg_name(rs1_name));
  reg_abi_name i_rs2_name (.reg_number(ex_rs2), .reg_name(rs2_name));

  decode_result_queue i_queue (
    .clk, .rst_n,
    .push       (ex_valid),
    .pop        (pop),
    .in_rd      (ex_rd),
    .in_rs1     (ex_rs1),
    .in_rs2     (ex_rs2),
    .in_imm     (ex_imm),
    .in_flag    (ex_flag),
    .in_rd_name (rd_name),
    .in_rs1_name(rs1_name),
    .in_rs2_name(rs2_name),
    .count, .head_rd, .head_rs1, .head_rs2, .head_imm, .head_flag,
    .head_rd_name, .head_rs1_name, .head_rs2_name
  );

endmodule

`default_nettype wire

// File: rtl/wb_decode_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module wb_decode_port
  import rv_decode_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [4:0]                wb_adr,
  input  logic [31:0]               wb_dat_w,
  input  logic [3:0]                wb_sel,  // every register is a full word, lanes not decoded
  output logic [31:0]               wb_dat_r,
  output logic                      wb_ack,
  output logic                      insn_valid,
  output logic [`INSN_WIDTH-1:0]    insn,
  output logic                      pop,
  input  logic [`COUNT_WIDTH-1:0]   count,
  input  logic [`FLAG_WIDTH-1:0]    head_flag,
  input  logic [`INSN_WIDTH-1:0]    head_imm,
  input  logic [`REG_NUM_WIDTH-1:0] head_rd,
  input  logic [`REG_NUM_WIDTH-1:0] head_rs1,
  input  logic [`REG_NUM_WIDTH-1:0] head_rs2,
  input  abi_name_t                 head_rd_name,
  input  abi_name_t                 head_rs1_name,
  input  abi_name_t                 head_rs2_name
);

  localparam logic [`COUNT_WIDTH-1:0] CREDIT_INIT = `COUNT_WIDTH'(`RESULT_DEPTH);

  logic                    req;
  logic                    insn_wr;
  logic                    accept;
  logic [`COUNT_WIDTH-1:0] credits;
  logic [31:0]             rd_data;

  // the request is still up in the ack cycle, so it must not count twice
  assign req     = wb_cyc && wb_stb && !wb_ack;
  assign insn_wr = wb_we && (wb_adr == `REG_INSN);
  assign accept  = req && !(insn_wr && (credits == '0)); // held write waits for a free slot

  assign insn_valid = accept && insn_wr;
  assign insn       = wb_dat_w;
  assign pop        = accept && wb_we && (wb_adr == `REG_POP);

  // one credit per queue slot not yet claimed by an instruction in flight or queued
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CREDIT_INIT;
    end else if (insn_valid) begin
      credits <= credits - 1'b1;
    end else if (pop && (count != '0)) begin
      credits <= credits + 1'b1;
    end
  end

  always_comb begin
    rd_data = '0;
    if (count != '0) begin
      case (wb_adr)
        `REG_FIELDS:   rd_data = {head_flag, 1'b0, head_rd, head_rs1, head_rs2};
        `REG_IMM:      rd_data = head_imm;
        `REG_RD_NAME:  rd_data = head_rd_name;
        `REG_RS1_NAME: rd_data = head_rs1_name;
        `REG_RS2_NAME: rd_data = head_rs2_name;
        default:       rd_data = '0;
      endcase
    end
    if (wb_adr == `REG_STATUS) begin
      rd_data = {{(32 - `COUNT_WIDTH){1'b0}}, count};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wb_dat_r <= wb_we ? 32'd0 : rd_data;
    end
  end

endmodule

`default_nettype wire
